// ==== tb.f ====
+incdir+source
source/bank_wrap_pkg.sv
source/write_router.sv
source/read_router.sv
source/read_collect.sv
source/bank_wrap_top.sv
bench/clock_gen.sv
bench/bank_model.sv
bench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_top -f tb.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

// ==== bench/tb_top.sv ====
`timescale 1ns/1ps
`include "bank_wrap_defs.svh"

module tb_top;
  import bank_wrap_pkg::*;

  typedef bank_wr_t [`NUM_BANKS-1:0] bank_wr_vec_t;
  typedef bank_rd_t [`NUM_BANKS-1:0] bank_rd_vec_t;
  typedef word_t [`NUM_RD_PORTS-1:0] rd_word_vec_t;
  typedef padr_t [`NUM_RD_PORTS-1:0] padr_vec_t;

  localparam int ADDRS         = 1 << (`BANK_BITS + `ROW_BITS);
  localparam int DRAIN         = `RD_LATENCY + 2;
  localparam int RANDOM_CYCLES = 200;
  // Reset, then the six tests in run order
  localparam int RUN_CYCLES  = 8 + 4 + 4 * 4 + 2 * (2 * ADDRS + DRAIN) + 4 * (4 + DRAIN)
    + (64 + DRAIN) + (RANDOM_CYCLES + DRAIN);
  localparam int CYCLE_LIMIT = RUN_CYCLES * 3 / 2;

  logic                        clk;
  logic                        arst_n;
  wr_req_t [`NUM_WR_PORTS-1:0] wr_req;
  rd_req_t [`NUM_RD_PORTS-1:0] rd_req;
  bank_wr_vec_t                bank_wr;
  bank_rd_vec_t                bank_rd;
  word_t [`NUM_BANKS-1:0]      bank_dout;
  rd_word_vec_t                rd_data;
  logic [`NUM_RD_PORTS-1:0]    rd_vld;
  padr_vec_t                   rd_padr;

  // Reference memory and expected outputs with one entry per pipeline stage
  word_t                    ref_mem [ADDRS];
  bank_wr_vec_t             exp_wr [`SKEW_MAX+1];
  bank_rd_vec_t             exp_rd [`SKEW_MAX+1];
  bank_wr_vec_t             exp_bank_wr;
  bank_rd_vec_t             exp_bank_rd;
  logic [`NUM_RD_PORTS-1:0] exp_vld [`RD_LATENCY];
  rd_word_vec_t             exp_data [`RD_LATENCY];
  padr_vec_t                exp_padr [`RD_LATENCY];
  int                       error_count = 0;
  int                       cycle_count = 0;
  int                       tests_passed = 0;

  clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(8)) clock_gen_inst (.*);
  bank_wrap_top bank_wrap_top_inst (.*);
  bank_model bank_model_inst (.*);

  always @(posedge clk or negedge arst_n) begin : ref_model
    bank_wr_vec_t             wr_next;
    bank_rd_vec_t             rd_next;
    logic [`NUM_RD_PORTS-1:0] vld_next;
    rd_word_vec_t             data_next;
    padr_vec_t                padr_next;
    if (!arst_n) begin
      exp_wr   <= '{default: '0};
      exp_rd   <= '{default: '0};
      exp_vld  <= '{default: '0};
      exp_data <= '{default: '0};
      exp_padr <= '{default: '0};
    end else begin
      wr_next   = '0;
      rd_next   = '0;
      vld_next  = '0;
      data_next = '0;
      padr_next = '0;
      for (int p = 0; p < `NUM_WR_PORTS; p++) begin
        if (wr_req[p].valid) begin
          wr_next[wr_req[p].bank] = '{write: 1'b1, row: wr_req[p].row, data: wr_req[p].data};
          ref_mem[{wr_req[p].bank, wr_req[p].row}] <= wr_req[p].data;
        end
      end
      // Reads see the memory before this edge's writes
      for (int p = 0; p < `NUM_RD_PORTS; p++) begin
        if (rd_req[p].valid) begin
          rd_next[rd_req[p].bank] = '{read: 1'b1, row: rd_req[p].row};
          vld_next[p]  = 1'b1;
          data_next[p] = ref_mem[{rd_req[p].bank, rd_req[p].row}];
          padr_next[p] = {rd_req[p].bank, rd_req[p].row};
        end
      end
      exp_wr[0]   <= wr_next;
      exp_rd[0]   <= rd_next;
      exp_vld[0]  <= vld_next;
      exp_data[0] <= data_next;
      exp_padr[0] <= padr_next;
      for (int s = 1; s <= `SKEW_MAX; s++) begin
        exp_wr[s] <= exp_wr[s-1];
        exp_rd[s] <= exp_rd[s-1];
      end
      for (int s = 1; s < `RD_LATENCY; s++) begin
        exp_vld[s]  <= exp_vld[s-1];
        exp_data[s] <= exp_data[s-1];
        exp_padr[s] <= exp_padr[s-1];
      end
    end
  end

  // Bank b sees its strobe one stage later per chain segment
  always_comb begin
    for (int b = 0; b < `NUM_BANKS; b++) begin
      exp_bank_wr[b] = exp_wr[b / `CHAIN_SEG][b];
      exp_bank_rd[b] = exp_rd[b / `CHAIN_SEG][b];
    end
  end

  function automatic bank_wr_vec_t wr_view(bank_wr_vec_t w);
    bank_wr_vec_t v;
    for (int b = 0; b < `NUM_BANKS; b++) begin
      v[b] = w[b].write ? w[b] : '0;
    end
    return v;
  endfunction

  function automatic bank_rd_vec_t rd_view(bank_rd_vec_t r);
    bank_rd_vec_t v;
    for (int b = 0; b < `NUM_BANKS; b++) begin
      v[b] = r[b].read ? r[b] : '0;
    end
    return v;
  endfunction

  function automatic padr_vec_t padr_view(padr_vec_t a, logic [`NUM_RD_PORTS-1:0] vld);
    padr_vec_t v;
    for (int p = 0; p < `NUM_RD_PORTS; p++) begin
      v[p] = vld[p] ? a[p] : '0;
    end
    return v;
  endfunction

  task automatic value_error(string name, logic [127:0] expected, logic [127:0] actual);
    $display("FAIL time=%0t signal=%s expected=%0h actual=%0h", $time, name, expected, actual);
    error_count++;
  endtask

  assert property (@(posedge clk) disable iff (!arst_n)
    wr_view(bank_wr) == wr_view(exp_bank_wr))
    else value_error("bank_wr", 128'(wr_view($sampled(exp_bank_wr))),
      128'(wr_view($sampled(bank_wr))));

  assert property (@(posedge clk) disable iff (!arst_n)
    rd_view(bank_rd) == rd_view(exp_bank_rd))
    else value_error("bank_rd", 128'(rd_view($sampled(exp_bank_rd))),
      128'(rd_view($sampled(bank_rd))));

  assert property (@(posedge clk) disable iff (!arst_n) rd_vld == exp_vld[`RD_LATENCY-1])
    else value_error("rd_vld", 128'($sampled(exp_vld[`RD_LATENCY-1])),
      128'($sampled(rd_vld)));

  // Idle ports expect zero here as well
  assert property (@(posedge clk) disable iff (!arst_n) rd_data == exp_data[`RD_LATENCY-1])
    else value_error("rd_data", 128'($sampled(exp_data[`RD_LATENCY-1])),
      128'($sampled(rd_data)));

  assert property (@(posedge clk) disable iff (!arst_n)
    padr_view(rd_padr, exp_vld[`RD_LATENCY-1])
      == padr_view(exp_padr[`RD_LATENCY-1], exp_vld[`RD_LATENCY-1]))
    else value_error("rd_padr",
      128'(padr_view($sampled(exp_padr[`RD_LATENCY-1]), $sampled(exp_vld[`RD_LATENCY-1]))),
      128'(padr_view($sampled(rd_padr), $sampled(exp_vld[`RD_LATENCY-1]))));

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #2;
    wr_req = '0;
    rd_req = '0;
  endtask

  task automatic idle(int cycles);
    repeat (cycles) next_cycle();
  endtask

  task automatic drive_write(int port, bank_t bank, row_t row, word_t data);
    wr_req[port] = '{valid: 1'b1, bank: bank, row: row, data: data};
  endtask

  task automatic drive_read(int port, bank_t bank, row_t row);
    rd_req[port] = '{valid: 1'b1, bank: bank, row: row};
  endtask

  task automatic report_test(int num, string name, int errors_before);
    if (error_count == errors_before) begin
      tests_passed++;
      $display("test %0d %s: pass", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, error_count - errors_before);
    end
  endtask

  task automatic single_write_skew();
    for (int b = 0; b < `NUM_BANKS; b++) begin
      drive_write(0, bank_t'(b), row_t'(b + 3), word_t'($urandom));
      next_cycle();
      idle(3);
    end
  endtask

  task automatic write_read_all();
    for (int p = 0; p < `NUM_WR_PORTS; p++) begin
      for (int a = 0; a < ADDRS; a++) begin
        drive_write(p, bank_t'(a >> `ROW_BITS), row_t'(a), {4'(p + 1), 6'(a), ~6'(a)});
        next_cycle();
      end
      for (int a = 0; a < ADDRS; a++) begin
        drive_read(p, bank_t'(a >> `ROW_BITS), row_t'(a));
        next_cycle();
      end
      idle(DRAIN);
    end
  endtask

  task automatic dual_port_pair();
    row_t r0;
    row_t r1;
    for (int i = 0; i < 4; i++) begin
      r0 = row_t'($urandom);
      r1 = row_t'($urandom);
      drive_write(0, bank_t'(i), r0, word_t'($urandom));
      drive_write(1, bank_t'(i + 1), r1, word_t'($urandom));
      next_cycle();
      idle(2);
      drive_read(0, bank_t'(i), r0);
      drive_read(1, bank_t'(i + 1), r1);
      next_cycle();
      idle(DRAIN);
    end
  endtask

  task automatic back_to_back_reads();
    for (int i = 0; i < 64; i++) begin
      drive_read(0, bank_t'(i), row_t'(i >> 2));
      drive_read(1, bank_t'(i + 2), row_t'(15 - (i >> 2)));
      next_cycle();
    end
    idle(DRAIN);
  endtask

  // Ports on one side always get distinct banks
  task automatic random_traffic();
    bank_t wb;
    bank_t rb;
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      wb = bank_t'($urandom);
      rb = bank_t'($urandom);
      if ($urandom % 2 == 1) begin
        drive_write(0, wb, row_t'($urandom), word_t'($urandom));
      end
      if ($urandom % 2 == 1) begin
        drive_write(1, bank_t'(wb + 1 + $urandom % 3), row_t'($urandom), word_t'($urandom));
      end
      if ($urandom % 4 != 0) begin
        drive_read(0, rb, row_t'($urandom));
      end
      if ($urandom % 4 != 0) begin
        drive_read(1, bank_t'(rb + 1 + $urandom % 3), row_t'($urandom));
      end
      next_cycle();
    end
    idle(DRAIN);
  endtask

  initial begin
    int errors_before;
    wr_req = '0;
    rd_req = '0;
    void'($urandom(87));
    wait (arst_n === 1'b1);

    errors_before = error_count;
    idle(4);
    report_test(1, "idle after reset", errors_before);
    errors_before = error_count;
    single_write_skew();
    report_test(2, "single write skew", errors_before);
    errors_before = error_count;
    write_read_all();
    report_test(3, "write and read every address", errors_before);
    errors_before = error_count;
    dual_port_pair();
    report_test(4, "dual port same cycle", errors_before);
    errors_before = error_count;
    back_to_back_reads();
    report_test(5, "back to back reads", errors_before);
    errors_before = error_count;
    random_traffic();
    report_test(6, "random traffic", errors_before);

    $display("tests 6, passed %0d, failed %0d, errors %0d", tests_passed, 6 - tests_passed,
      error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== bench/bank_model.sv ====
`timescale 1ns/1ps
`include "bank_wrap_defs.svh"

module bank_model (
  input  logic                                      clk,
  input  logic                                      arst_n,
  input  bank_wrap_pkg::bank_wr_t [`NUM_BANKS-1:0] bank_wr,
  input  bank_wrap_pkg::bank_rd_t [`NUM_BANKS-1:0] bank_rd,
  output bank_wrap_pkg::word_t    [`NUM_BANKS-1:0] bank_dout
);
  import bank_wrap_pkg::*;

  for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
    word_t mem [1 << `ROW_BITS];
    word_t dout_pipe [`SRAM_DELAY];

    always @(posedge clk) begin
      if (bank_wr[b].write) begin
        mem[bank_wr[b].row] <= bank_wr[b].data;
      end
    end

    // Read returns the old word when a write to that row lands on the same edge
    always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        dout_pipe <= '{default: '0};
      end else begin
        dout_pipe[0] <= bank_rd[b].read ? mem[bank_rd[b].row] : '0;
        for (int s = 1; s < `SRAM_DELAY; s++) begin
          dout_pipe[s] <= dout_pipe[s-1];
        end
      end
    end

    assign bank_dout[b] = dout_pipe[`SRAM_DELAY-1];
  end

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release lands just after an edge, like the rest of the stimulus
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    arst_n = 1'b1;
  end

endmodule

// ==== source/bank_wrap_top.sv ====
`timescale 1ns/1ps
`include "bank_wrap_defs.svh"

module bank_wrap_top (
  input  logic                                         clk,
  input  logic                                         arst_n,
  input  bank_wrap_pkg::wr_req_t  [`NUM_WR_PORTS-1:0] wr_req,
  input  bank_wrap_pkg::rd_req_t  [`NUM_RD_PORTS-1:0] rd_req,
  output bank_wrap_pkg::bank_wr_t [`NUM_BANKS-1:0]    bank_wr,
  output bank_wrap_pkg::bank_rd_t [`NUM_BANKS-1:0]    bank_rd,
  input  bank_wrap_pkg::word_t    [`NUM_BANKS-1:0]    bank_dout,
  output bank_wrap_pkg::word_t    [`NUM_RD_PORTS-1:0] rd_data,
  output logic                    [`NUM_RD_PORTS-1:0] rd_vld,
  output bank_wrap_pkg::padr_t    [`NUM_RD_PORTS-1:0] rd_padr
);

  // Per-port bank selects aligned to bank data
  logic [`NUM_RD_PORTS-1:0][`NUM_BANKS-1:0] rd_sel;

  write_router write_router_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .wr_req  (wr_req),
    .bank_wr (bank_wr)
  );

  read_router read_router_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .rd_req  (rd_req),
    .bank_rd (bank_rd),
    .rd_sel  (rd_sel),
    .rd_vld  (rd_vld),
    .rd_padr (rd_padr)
  );

  read_collect read_collect_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_sel    (rd_sel),
    .bank_dout (bank_dout),
    .rd_data   (rd_data)
  );

endmodule

// ==== source/read_collect.sv ====
`timescale 1ns/1ps
`include "bank_wrap_defs.svh"

module read_collect (
  input  logic                                       clk,
  input  logic                                       arst_n,
  input  logic [`NUM_RD_PORTS-1:0][`NUM_BANKS-1:0]   rd_sel,
  input  bank_wrap_pkg::word_t [`NUM_BANKS-1:0]      bank_dout,
  output bank_wrap_pkg::word_t [`NUM_RD_PORTS-1:0]   rd_data
);
  import bank_wrap_pkg::*;

  word_t seg_d [`SKEW_MAX][`NUM_RD_PORTS];
  word_t seg_q [`SKEW_MAX][`NUM_RD_PORTS];

  // Each port's chain starts at zero and picks up the selected bank's word
  always_comb begin
    word_t cur [`NUM_RD_PORTS];
    for (int p = 0; p < `NUM_RD_PORTS; p++) begin
      cur[p] = '0;
    end
    for (int b = 0; b < `NUM_BANKS; b++) begin
      for (int p = 0; p < `NUM_RD_PORTS; p++) begin
        if (rd_sel[p][b]) begin
          cur[p] = bank_dout[b];
        end
      end
      // Later segments see their data one cycle later, so cut the chain here
      if ((b % `CHAIN_SEG) == (`CHAIN_SEG - 1) && b != (`NUM_BANKS - 1)) begin
        seg_d[b / `CHAIN_SEG] = cur;
        cur = seg_q[b / `CHAIN_SEG];
      end
    end
    for (int p = 0; p < `NUM_RD_PORTS; p++) begin
      rd_data[p] = cur[p];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int s = 0; s < `SKEW_MAX; s++) begin
        for (int p = 0; p < `NUM_RD_PORTS; p++) begin
          seg_q[s][p] <= '0;
        end
      end
    end else begin
      seg_q <= seg_d;
    end
  end

endmodule

// ==== source/read_router.sv ====
`timescale 1ns/1ps
`include "bank_wrap_defs.svh"

module read_router (
  input  logic                                          clk,
  input  logic                                          arst_n,
  input  bank_wrap_pkg::rd_req_t  [`NUM_RD_PORTS-1:0]  rd_req,
  output bank_wrap_pkg::bank_rd_t [`NUM_BANKS-1:0]     bank_rd,
  output logic [`NUM_RD_PORTS-1:0][`NUM_BANKS-1:0]     rd_sel,
  output logic [`NUM_RD_PORTS-1:0]                     rd_vld,
  output bank_wrap_pkg::padr_t    [`NUM_RD_PORTS-1:0]  rd_padr
);
  import bank_wrap_pkg::*;

  logic [`NUM_RD_PORTS-1:0]         hit_d [`NUM_BANKS];
  row_t                             row_d [`NUM_BANKS];
  logic [`NUM_RD_PORTS-1:0]         vld_pipe [`RD_LATENCY];
  padr_t [`NUM_RD_PORTS-1:0]        padr_pipe [`RD_LATENCY];

  always_comb begin
    for (int b = 0; b < `NUM_BANKS; b++) begin
      hit_d[b] = '0;
      row_d[b] = '0;
      for (int p = 0; p < `NUM_RD_PORTS; p++) begin
        if (rd_req[p].valid && rd_req[p].bank == bank_t'(b)) begin
          hit_d[b][p] = 1'b1;
          row_d[b] = rd_req[p].row;
        end
      end
    end
  end

  for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
    localparam int SEG = b / `CHAIN_SEG;
    // Select reaches the collector together with this bank's data
    localparam int DEPTH = 1 + `SRAM_DELAY + SEG;

    logic [`NUM_RD_PORTS-1:0] hit_pipe [DEPTH];
    row_t                     row_pipe [SEG+1];

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        for (int s = 0; s < DEPTH; s++) begin
          hit_pipe[s] <= '0;
        end
      end else begin
        hit_pipe[0] <= hit_d[b];
        for (int s = 1; s < DEPTH; s++) begin
          hit_pipe[s] <= hit_pipe[s-1];
        end
      end
    end

    always_ff @(posedge clk) begin
      row_pipe[0] <= row_d[b];
      for (int s = 1; s <= SEG; s++) begin
        row_pipe[s] <= row_pipe[s-1];
      end
    end

    // Stage SEG doubles as the skewed read strobe
    assign bank_rd[b].read = |hit_pipe[SEG];
    assign bank_rd[b].row  = row_pipe[SEG];

    for (genvar p = 0; p < `NUM_RD_PORTS; p++) begin : g_port
      assign rd_sel[p][b] = hit_pipe[DEPTH-1][p];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int s = 0; s < `RD_LATENCY; s++) begin
        vld_pipe[s] <= '0;
      end
    end else begin
      for (int p = 0; p < `NUM_RD_PORTS; p++) begin
        vld_pipe[0][p] <= rd_req[p].valid;
      end
      for (int s = 1; s < `RD_LATENCY; s++) begin
        vld_pipe[s] <= vld_pipe[s-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < `NUM_RD_PORTS; p++) begin
      padr_pipe[0][p] <= {rd_req[p].bank, rd_req[p].row};
    end
    for (int s = 1; s < `RD_LATENCY; s++) begin
      padr_pipe[s] <= padr_pipe[s-1];
    end
  end

  assign rd_vld  = vld_pipe[`RD_LATENCY-1];
  assign rd_padr = padr_pipe[`RD_LATENCY-1];

endmodule

// ==== source/write_router.sv ====
`timescale 1ns/1ps
`include "bank_wrap_defs.svh"

module write_router (
  input  logic                                         clk,
  input  logic                                         arst_n,
  input  bank_wrap_pkg::wr_req_t  [`NUM_WR_PORTS-1:0] wr_req,
  output bank_wrap_pkg::bank_wr_t [`NUM_BANKS-1:0]    bank_wr
);
  import bank_wrap_pkg::*;

  logic [`NUM_WR_PORTS-1:0] mask_d [`NUM_BANKS];
  row_t                     row_d [`NUM_BANKS];
  logic [`NUM_WR_PORTS-1:0] bank_mask [`NUM_BANKS];
  word_t                    bank_din [`NUM_BANKS];
  word_t                    data_q [`NUM_WR_PORTS];
  word_t                    seg_d [`SKEW_MAX][`NUM_WR_PORTS];
  word_t                    seg_q [`SKEW_MAX][`NUM_WR_PORTS];

  // Per-bank port mask where the higher port takes the row on a collision
  always_comb begin
    for (int b = 0; b < `NUM_BANKS; b++) begin
      mask_d[b] = '0;
      row_d[b] = '0;
      for (int p = 0; p < `NUM_WR_PORTS; p++) begin
        if (wr_req[p].valid && wr_req[p].bank == bank_t'(b)) begin
          mask_d[b][p] = 1'b1;
          row_d[b] = wr_req[p].row;
        end
      end
    end
  end

  for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
    localparam int SEG = b / `CHAIN_SEG;

    logic [`NUM_WR_PORTS-1:0] mask_pipe [SEG+1];
    row_t                     row_pipe [SEG+1];

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        for (int s = 0; s <= SEG; s++) begin
          mask_pipe[s] <= '0;
        end
      end else begin
        mask_pipe[0] <= mask_d[b];
        for (int s = 1; s <= SEG; s++) begin
          mask_pipe[s] <= mask_pipe[s-1];
        end
      end
    end

    always_ff @(posedge clk) begin
      row_pipe[0] <= row_d[b];
      for (int s = 1; s <= SEG; s++) begin
        row_pipe[s] <= row_pipe[s-1];
      end
    end

    assign bank_mask[b]     = mask_pipe[SEG];
    assign bank_wr[b].write = |mask_pipe[SEG];
    assign bank_wr[b].row   = row_pipe[SEG];
    assign bank_wr[b].data  = bank_din[b];
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < `NUM_WR_PORTS; p++) begin
      data_q[p] <= wr_req[p].data;
    end
  end

  // Data chain across the banks is cut by a register at each inner segment end
  always_comb begin
    word_t cur [`NUM_WR_PORTS];
    cur = data_q;
    for (int b = 0; b < `NUM_BANKS; b++) begin
      bank_din[b] = '0;
      for (int p = 0; p < `NUM_WR_PORTS; p++) begin
        bank_din[b] = bank_din[b] | (cur[p] & {`WIDTH{bank_mask[b][p]}});
      end
      if ((b % `CHAIN_SEG) == (`CHAIN_SEG - 1) && b != (`NUM_BANKS - 1)) begin
        seg_d[b / `CHAIN_SEG] = cur;
        cur = seg_q[b / `CHAIN_SEG];
      end
    end
  end

  always_ff @(posedge clk) begin
    seg_q <= seg_d;
  end

endmodule

// ==== source/bank_wrap_pkg.sv ====
`include "bank_wrap_defs.svh"

package bank_wrap_pkg;

  typedef logic [`WIDTH-1:0]                word_t;
  typedef logic [`BANK_BITS-1:0]            bank_t;
  typedef logic [`ROW_BITS-1:0]             row_t;
  // Bank in the upper bits, row below
  typedef logic [`BANK_BITS+`ROW_BITS-1:0]  padr_t;

  typedef struct packed {
    logic  valid;
    bank_t bank;
    row_t  row;
    word_t data;
  } wr_req_t;

  typedef struct packed {
    logic  valid;
    bank_t bank;
    row_t  row;
  } rd_req_t;

  typedef struct packed {
    logic  write;
    row_t  row;
    word_t data;
  } bank_wr_t;

  typedef struct packed {
    logic read;
    row_t row;
  } bank_rd_t;

endpackage

// ==== source/bank_wrap_defs.svh ====
`ifndef BANK_WRAP_DEFS_SVH
`define BANK_WRAP_DEFS_SVH

// Data word and port counts
`define WIDTH        16
`define NUM_WR_PORTS 2
`define NUM_RD_PORTS 2

// Bank geometry
`define NUM_BANKS    4
`define BANK_BITS    2
`define ROW_BITS     4

// Banks sharing one chain segment
`define CHAIN_SEG    2

// Read latency of the external SRAM banks
`define SRAM_DELAY   2

`define SKEW_MAX     ((`NUM_BANKS - 1) / `CHAIN_SEG)
`define RD_LATENCY   (1 + `SRAM_DELAY + `SKEW_MAX)

`endif
